//--- lfsr_rng.sv
/*
 * Free-running 32 bit Galois shift register.
 * Steps once per accepted pick, holds otherwise.
 * The caller slices N out of the state before the step.
 */
`timescale 1ns/1ps

module lfsr_rng import unsat_pick_pkg::*; #(
    parameter logic [31:0] LFSR_SEED = DEF_LFSR_SEED
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        step_i,
    output logic [31:0] value_o
);

    logic [31:0] state;
    logic [31:0] next_state;

    // shift right, fold taps back in when a one drops out
    assign next_state = {1'b0, state[31:1]} ^ (state[0] ? LFSR_POLY : 32'h0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LFSR_SEED;
        end else if (step_i) begin
            state <= next_state;
        end
    end

    // current state, not the stepped one
    assign value_o = state;

endmodule

//--- list.f
unsat_pick_pkg.sv
table_load_if.sv
recip_table.sv
lfsr_rng.sv
mod_reduce.sv
unsat_buffer.sv
pick_ctrl.sv
unsat_pick_top.sv
unsat_pick_tb.sv

//--- mod_reduce.sv
/*
 * Four stage N mod m without a divider.
 * Multiplies N by the stored reciprocal of m, takes the high bits as the
 * quotient estimate, subtracts quotient times m and corrects once.
 * The estimate is low by at most one, so a single correction is enough.
 * m and the reciprocal arrive one cycle after N and valid.
 */
`timescale 1ns/1ps

module mod_reduce import unsat_pick_pkg::*; #(
    parameter int BUFFER_DEPTH = DEF_BUFFER_DEPTH,
    parameter int RAND_W = DEF_RAND_W,
    parameter int RECIP_W = DEF_RECIP_W
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            valid_i,
    input  logic [RAND_W-1:0]               n_i,
    input  logic [$clog2(BUFFER_DEPTH):0]   m_i,
    input  logic [RECIP_W-1:0]              recip_i,
    output logic                            valid_o,
    output logic [$clog2(BUFFER_DEPTH)-1:0] index_o
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = ADDR_W + 1;
    localparam int PROD_W = RAND_W + RECIP_W;

    // valid bit per stage
    logic v1;
    logic v2;
    logic v3;
    logic v4;

    // stage payloads
    logic [RAND_W-1:0] n1;
    logic [RAND_W-1:0] n2;
    logic [CNT_W-1:0]  m2;
    logic [CNT_W-1:0]  m3;
    logic [PROD_W-1:0] prod2;
    logic [CNT_W-1:0]  rem3;
    logic [ADDR_W-1:0] idx4;

    // combinational pieces between stages
    logic [RAND_W-1:0]       quot;
    logic [RAND_W+CNT_W-1:0] qm_full;
    logic [RAND_W-1:0]       diff;
    logic [CNT_W-1:0]        corr;

    // quotient estimate is the integer part of N * (1/m)
    assign quot = prod2[PROD_W-1:RECIP_W];
    assign qm_full = quot * m2;
    // true value below 2m, low bits are exact
    assign diff = n2 - qm_full[RAND_W-1:0];
    // one correction brings it below m
    assign corr = (rem3 >= m3) ? rem3 - m3 : rem3;

    // valid chain
    always_ff @(posedge clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
            v4 <= 1'b0;
        end else begin
            v1 <= valid_i;
            v2 <= v1;
            v3 <= v2;
            v4 <= v3;
        end
    end

    // data path
    always_ff @(posedge clk) begin
        // stage 1, line N up with the table read
        n1 <= n_i;
        // stage 2, multiply
        n2 <= n1;
        m2 <= m_i;
        prod2 <= n1 * recip_i;
        // stage 3, raw remainder
        m3 <= m2;
        rem3 <= diff[CNT_W-1:0];
        // stage 4, corrected index
        idx4 <= corr[ADDR_W-1:0];
    end

    assign valid_o = v4;
    assign index_o = idx4;

endmodule

//--- pick_ctrl.sv
/*
 * Pick control.
 * During setup the table port carries the external load, picks are ignored.
 * Otherwise a pick at a nonzero count is accepted, reads the reciprocal at
 * the live count and samples that count for the pipeline.
 * A pick at count zero is dropped and sets a sticky flag.
 */
`timescale 1ns/1ps

module pick_ctrl import unsat_pick_pkg::*; #(
    parameter int BUFFER_DEPTH = DEF_BUFFER_DEPTH,
    parameter int RECIP_W = DEF_RECIP_W
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          setup_i,
    input  logic [$clog2(BUFFER_DEPTH):0] load_addr_i,
    input  logic [RECIP_W-1:0]            load_data_i,
    input  logic                          pick_i,
    input  logic                          clear_flag_i,
    input  logic [$clog2(BUFFER_DEPTH):0] count_i,
    output logic                          pick_acc_o,
    output logic [$clog2(BUFFER_DEPTH):0] m_o,
    output logic                          div_zero_o,
    table_load_if.master                  tbl
);

    logic count_zero;
    logic pick_live;
    logic pick_acc;
    logic div_zero;

    assign count_zero = (count_i == '0);
    // picks only count outside setup
    assign pick_live = pick_i & ~setup_i;
    assign pick_acc = pick_live & ~count_zero;

    // table port, load in setup, read at the count on a pick
    assign tbl.en = setup_i | pick_acc;
    assign tbl.we = setup_i;
    assign tbl.addr = setup_i ? load_addr_i : count_i;
    assign tbl.wdata = load_data_i;

    // m lines up with the table read data
    always_ff @(posedge clk) begin
        if (pick_acc) begin
            m_o <= count_i;
        end
    end

    // sticky divide by zero, set beats clear
    always_ff @(posedge clk) begin
        if (reset) begin
            div_zero <= 1'b0;
        end else if (pick_live && count_zero) begin
            div_zero <= 1'b1;
        end else if (clear_flag_i) begin
            div_zero <= 1'b0;
        end
    end

    assign pick_acc_o = pick_acc;
    assign div_zero_o = div_zero;

endmodule

//--- recip_table.sv
/*
 * Fixed point reciprocal RAM, one entry per possible count.
 * Loaded from outside during setup, read at the live count on a pick.
 * Single port, registered read, write-first when enabled.
 */
`timescale 1ns/1ps

module recip_table import unsat_pick_pkg::*; #(
    parameter int BUFFER_DEPTH = DEF_BUFFER_DEPTH,
    parameter int RECIP_W = DEF_RECIP_W
) (
    input  logic               clk,
    table_load_if.slave        tbl,
    output logic [RECIP_W-1:0] rdata_o
);

    // entries 0 .. BUFFER_DEPTH, entry 0 never read
    logic [RECIP_W-1:0] mem [0:BUFFER_DEPTH];

    // single port block RAM
    always_ff @(posedge clk) begin
        if (tbl.en) begin
            if (tbl.we) begin
                mem[tbl.addr] <= tbl.wdata;
                // write-first, new data shows on the read port
                rdata_o <= tbl.wdata;
            end else begin
                rdata_o <= mem[tbl.addr];
            end
        end
    end

endmodule

//--- table_load_if.sv
/*
 * Port of the reciprocal table.
 * The controller drives it as master, the table RAM sits on the slave side.
 * The address is one bit wider than a buffer address so a full count fits.
 */
`timescale 1ns/1ps

interface table_load_if import unsat_pick_pkg::*; #(
    parameter int ADDR_W = $clog2(DEF_BUFFER_DEPTH) + 1,
    parameter int DATA_W = DEF_RECIP_W
) ();

    logic              en;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // controller side
    modport master (output en, output we, output addr, output wdata);
    // RAM side
    modport slave (input en, input we, input addr, input wdata);

endinterface

//--- unsat_buffer.sv
/*
 * Store of unsatisfied clause ids.
 * Ids are appended at the live count, clear empties it in one cycle.
 * Indexed reads are registered and return the index and a valid
 * alongside the id, one cycle after the request.
 */
`timescale 1ns/1ps

module unsat_buffer import unsat_pick_pkg::*; #(
    parameter int BUFFER_DEPTH = DEF_BUFFER_DEPTH
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            push_i,
    input  clause_id_t                      push_id_i,
    input  logic                            clear_i,
    output logic [$clog2(BUFFER_DEPTH):0]   count_o,
    input  logic                            rd_en_i,
    input  logic [$clog2(BUFFER_DEPTH)-1:0] rd_index_i,
    output logic                            rd_valid_o,
    output logic [$clog2(BUFFER_DEPTH)-1:0] rd_index_o,
    output clause_id_t                      rd_id_o
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = ADDR_W + 1;
    localparam logic [CNT_W-1:0] FULL = CNT_W'(BUFFER_DEPTH);

    clause_id_t       mem [0:BUFFER_DEPTH-1];
    logic [CNT_W-1:0] count;
    logic             push_ok;

    // clear wins over push, push at full depth dropped
    assign push_ok = push_i & ~clear_i & (count != FULL);

    always_ff @(posedge clk) begin
        if (reset || clear_i) begin
            count <= '0;
        end else if (push_ok) begin
            count <= count + 1'b1;
        end
    end

    // append at the current count
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[count[ADDR_W-1:0]] <= push_id_i;
        end
    end

    // read strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    // registered read, index travels with the id
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_id_o <= mem[rd_index_i];
            rd_index_o <= rd_index_i;
        end
    end

    assign count_o = count;

endmodule

//--- unsat_pick_pkg.sv
/*
 * Shared definitions for the unsatisfied clause picker.
 * Holds the clause id type, the default widths handed to the top level
 * and the feedback mask of the random generator.
 */
package unsat_pick_pkg;

    // one clause id as stored in the buffer
    typedef logic [15:0] clause_id_t;

    // buffer depth, address is log2 of it, count one bit wider
    parameter int DEF_BUFFER_DEPTH = 1024;
    // width of N and where it sits in the generator word
    parameter int DEF_RAND_W = 18;
    parameter int DEF_RAND_OFFSET = 10;
    // reciprocal entry, all bits fractional
    // entry m holds floor(2^32 / m), entry 1 saturates to all ones
    parameter int DEF_RECIP_W = 32;

    // galois tap mask, x^32 + x^22 + x^2 + x + 1
    parameter logic [31:0] LFSR_POLY = 32'h8020_0003;
    // must be nonzero or the generator locks up
    parameter logic [31:0] DEF_LFSR_SEED = 32'h0000_0001;

endpackage

//--- unsat_pick_tb.sv
/*
 * Testbench for the random unsatisfied clause picker.
 * Loads the reciprocal table, pushes ids and issues picks while a model
 * tracks the count, buffer contents, generator and sticky flag.
 * Expected results are queued per accepted pick and compared on arrival.
 */
`timescale 1ns/1ps

module unsat_pick_tb import unsat_pick_pkg::*; ();

    localparam int PERIOD = 8;
    localparam int DEPTH = DEF_BUFFER_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W = ADDR_W + 1;
    // table load, single picks, bursts, boundary fills, zero count
    localparam int TEST_CYCLES = (DEPTH + 1) + 120 + 60 + (DEPTH + 7 * 24 + 20) + 40;
    localparam int MARGIN = 200;

    logic clk;
    logic reset;
    logic setup_i;
    logic [CNT_W-1:0] load_addr_i;
    logic [DEF_RECIP_W-1:0] load_data_i;
    logic push_i;
    clause_id_t push_id_i;
    logic clear_i;
    logic pick_i;
    logic clear_flag_i;
    logic [CNT_W-1:0] count_o;
    logic pick_valid_o;
    logic [ADDR_W-1:0] index_o;
    clause_id_t clause_o;
    logic div_zero_o;

    // model state
    clause_id_t model_mem [0:DEPTH-1];
    int model_count;
    logic [31:0] model_lfsr;
    logic model_flag;
    int cycle;
    string test_name;
    int unsigned seed;

    // expected results, oldest first
    int due_q[$];
    logic [ADDR_W-1:0] idx_q[$];
    clause_id_t id_q[$];

    unsat_pick_top #(
        .BUFFER_DEPTH(DEPTH), .RAND_W(DEF_RAND_W), .RAND_OFFSET(DEF_RAND_OFFSET),
        .RECIP_W(DEF_RECIP_W), .LFSR_SEED(DEF_LFSR_SEED)
    ) UUT (
        .clk(clk), .reset(reset), .setup_i(setup_i), .load_addr_i(load_addr_i),
        .load_data_i(load_data_i), .push_i(push_i), .push_id_i(push_id_i),
        .clear_i(clear_i), .pick_i(pick_i), .clear_flag_i(clear_flag_i),
        .count_o(count_o), .pick_valid_o(pick_valid_o), .index_o(index_o),
        .clause_o(clause_o), .div_zero_o(div_zero_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_index(input logic [ADDR_W-1:0] exp, input logic [ADDR_W-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error [%s] index expected %0d actual %0d",
                test_name, exp, act));
        end
    endtask

    task automatic check_clause(input clause_id_t exp, input clause_id_t act);
        if (exp !== act) begin
            fail_run($sformatf("** Error [%s] clause expected %h actual %h",
                test_name, exp, act));
        end
    endtask

    task automatic check_flag(input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("** Error [%s] flag expected %b actual %b",
                test_name, exp, act));
        end
    endtask

    task automatic check_count(input logic [CNT_W-1:0] exp, input logic [CNT_W-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("** Error [%s] count expected %0d actual %0d",
                test_name, exp, act));
        end
    endtask

    // galois step, shift right and fold in the taps on a dropped one
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_POLY : 32'h0);
    endfunction

    // floor(2^32 / m), entry 1 saturates
    function automatic logic [31:0] recip_value(input int m);
        logic [63:0] q;
        if (m == 0) begin
            return 32'h0;
        end
        if (m == 1) begin
            return 32'hffff_ffff;
        end
        q = 64'h1_0000_0000 / 64'(m);
        return q[31:0];
    endfunction

    // exact N mod m
    function automatic logic [ADDR_W-1:0] ref_index(input int n, input int m);
        return ADDR_W'(n % m);
    endfunction

    // one table entry, pick level given by the caller
    task automatic load_entry(input int addr, input logic pick);
        @(posedge clk);
        #1;
        setup_i = 1'b1;
        load_addr_i = CNT_W'(addr);
        load_data_i = recip_value(addr);
        pick_i = pick;
        push_i = 1'b0;
    endtask

    // drive one cycle outside setup and update the model
    task automatic drive_cycle(input logic pick, input logic push, input logic clr,
                               input logic clr_flag);
        int n;
        logic [ADDR_W-1:0] idx;
        clause_id_t id;
        id = clause_id_t'($urandom);
        @(posedge clk);
        #1;
        setup_i = 1'b0;
        pick_i = pick;
        push_i = push;
        push_id_i = id;
        clear_i = clr;
        clear_flag_i = clr_flag;
        // count and N as seen by this cycle's pick
        if (pick && model_count == 0) begin
            model_flag = 1'b1;
        end else begin
            if (clr_flag) begin
                model_flag = 1'b0;
            end
            if (pick) begin
                n = int'(model_lfsr[DEF_RAND_OFFSET +: DEF_RAND_W]);
                idx = ref_index(n, model_count);
                due_q.push_back(cycle + 5);
                idx_q.push_back(idx);
                id_q.push_back(model_mem[idx]);
                model_lfsr = lfsr_step(model_lfsr);
            end
        end
        if (clr) begin
            model_count = 0;
        end else if (push && model_count < DEPTH) begin
            model_mem[model_count] = id;
            model_count++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // results in order, exactly on the due cycle
    always @(negedge clk) begin
        if (due_q.size() > 0 && due_q[0] < cycle) begin
            fail_run($sformatf("[%s] a pick result did not arrive on time", test_name));
        end else if (pick_valid_o) begin
            if (due_q.size() == 0) begin
                fail_run($sformatf("[%s] pick_valid_o rose with no pick pending", test_name));
            end else if (due_q[0] != cycle) begin
                fail_run($sformatf("[%s] pick result came early", test_name));
            end else begin
                check_index(idx_q[0], index_o);
                check_clause(id_q[0], clause_o);
                void'(due_q.pop_front());
                void'(idx_q.pop_front());
                void'(id_q.pop_front());
            end
        end
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * PERIOD);
        fail_run("watchdog expired, the run did not finish in time");
    end

    initial begin
        seed = 32'haddf_a660;
        void'($urandom(seed));
        clk = 1'b0;
        reset = 1'b1;
        setup_i = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        push_i = 1'b0;
        push_id_i = '0;
        clear_i = 1'b0;
        pick_i = 1'b0;
        clear_flag_i = 1'b0;
        cycle = 0;
        model_count = 0;
        model_lfsr = DEF_LFSR_SEED;
        model_flag = 1'b0;
        foreach (model_mem[i]) model_mem[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "reset";
        idle(1);
        check_count('0, count_o);
        check_flag(1'b0, div_zero_o);

        // picks during the load must be ignored
        test_name = "table_load";
        for (int a = 0; a <= DEPTH; a++) begin
            load_entry(a, a[0]);
        end
        idle(2);
        check_flag(1'b0, div_zero_o);

        test_name = "single_picks";
        repeat (20) drive_cycle(1'b0, 1'b1, 1'b0, 1'b0);
        idle(1);
        check_count(CNT_W'(model_count), count_o);
        // pick in setup at a nonzero count, no result and no generator step
        load_entry(model_count, 1'b1);
        repeat (10) begin
            drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
            idle(6);
        end

        // count moves under a burst
        test_name = "back_to_back";
        repeat (40) drive_cycle(1'b1, 1'($urandom % 2), 1'b0, 1'b0);
        idle(8);

        test_name = "boundary_counts";
        drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
        for (int k = 0; k < 7; k++) begin
            int target;
            case (k)
                0: target = 1;
                1: target = 2;
                2: target = 4;
                3: target = 64;
                4: target = 512;
                5: target = DEPTH - 1;
                default: target = DEPTH;
            endcase
            while (model_count < target) begin
                drive_cycle(1'b0, 1'b1, 1'b0, 1'b0);
            end
            repeat (16) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
            idle(6);
        end
        // push at full depth is dropped
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0);
        idle(1);
        check_count(CNT_W'(DEPTH), count_o);

        test_name = "zero_count";
        drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
        idle(1);
        check_count('0, count_o);
        check_flag(1'b0, div_zero_o);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
        idle(1);
        check_flag(1'b1, div_zero_o);
        // stays up, no result comes out
        idle(6);
        check_flag(model_flag, div_zero_o);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1);
        idle(1);
        check_flag(1'b0, div_zero_o);

        idle(10);
        if (due_q.size() != 0) begin
            fail_run($sformatf("%0d expected pick results never came out", due_q.size()));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- unsat_pick_top.sv
/*
 * Random unsatisfied clause picker for a local search SAT solver.
 * Load the reciprocal table with setup_i high, push clause ids, then pulse
 * pick_i. Five cycles after an accepted pick clause_o and index_o are valid
 * with pick_valid_o high for one cycle. A pick at count zero gives no result
 * and raises div_zero_o until clear_flag_i.
 */
`timescale 1ns/1ps

module unsat_pick_top import unsat_pick_pkg::*; #(
    parameter int BUFFER_DEPTH = DEF_BUFFER_DEPTH,
    parameter int RAND_W = DEF_RAND_W,
    parameter int RAND_OFFSET = DEF_RAND_OFFSET,
    parameter int RECIP_W = DEF_RECIP_W,
    parameter logic [31:0] LFSR_SEED = DEF_LFSR_SEED
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            setup_i,
    input  logic [$clog2(BUFFER_DEPTH):0]   load_addr_i,
    input  logic [RECIP_W-1:0]              load_data_i,
    input  logic                            push_i,
    input  clause_id_t                      push_id_i,
    input  logic                            clear_i,
    input  logic                            pick_i,
    input  logic                            clear_flag_i,
    output logic [$clog2(BUFFER_DEPTH):0]   count_o,
    output logic                            pick_valid_o,
    output logic [$clog2(BUFFER_DEPTH)-1:0] index_o,
    output clause_id_t                      clause_o,
    output logic                            div_zero_o
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = ADDR_W + 1;

    logic              pick_acc;
    logic [CNT_W-1:0]  m;
    logic [31:0]       rng_value;
    logic [RECIP_W-1:0] recip;
    logic              red_valid;
    logic [ADDR_W-1:0] red_index;

    table_load_if #(.ADDR_W(CNT_W), .DATA_W(RECIP_W)) tbl_if ();

    pick_ctrl #(.BUFFER_DEPTH(BUFFER_DEPTH), .RECIP_W(RECIP_W)) u_ctrl (
        .clk(clk), .reset(reset), .setup_i(setup_i), .load_addr_i(load_addr_i),
        .load_data_i(load_data_i), .pick_i(pick_i), .clear_flag_i(clear_flag_i),
        .count_i(count_o), .pick_acc_o(pick_acc), .m_o(m), .div_zero_o(div_zero_o),
        .tbl(tbl_if.master)
    );

    recip_table #(.BUFFER_DEPTH(BUFFER_DEPTH), .RECIP_W(RECIP_W)) u_table (
        .clk(clk), .tbl(tbl_if.slave), .rdata_o(recip)
    );

    lfsr_rng #(.LFSR_SEED(LFSR_SEED)) u_rng (
        .clk(clk), .reset(reset), .step_i(pick_acc), .value_o(rng_value)
    );

    // N is a slice of the generator word
    mod_reduce #(.BUFFER_DEPTH(BUFFER_DEPTH), .RAND_W(RAND_W), .RECIP_W(RECIP_W)) u_mod (
        .clk(clk), .reset(reset), .valid_i(pick_acc),
        .n_i(rng_value[RAND_OFFSET +: RAND_W]), .m_i(m), .recip_i(recip),
        .valid_o(red_valid), .index_o(red_index)
    );

    unsat_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_buf (
        .clk(clk), .reset(reset), .push_i(push_i), .push_id_i(push_id_i),
        .clear_i(clear_i), .count_o(count_o), .rd_en_i(red_valid),
        .rd_index_i(red_index), .rd_valid_o(pick_valid_o), .rd_index_o(index_o),
        .rd_id_o(clause_o)
    );

endmodule
